//--- verilog/ex_pkg.sv
package ex_pkg;

    localparam int XLEN = 32;
    localparam int REG_W = 5;
    localparam int CFG_ADDR_W = 1;

    localparam logic [CFG_ADDR_W-1:0] CTRL_ADDR = 1'b0;  // Forwarding enables.
    localparam logic [CFG_ADDR_W-1:0] COUNT_ADDR = 1'b1; // Forwarded-operand counter.

    typedef enum logic [6:0] {
        OP_OTHER  = 7'b0000000,
        OP_IMM    = 7'b0010011,
        OP_STORE  = 7'b0100011,
        OP_REG    = 7'b0110011,
        OP_BRANCH = 7'b1100011
    } opcode_e;

    // Operand source picked by the forwarding unit.
    typedef enum logic [1:0] {
        FWD_NONE = 2'b00,
        FWD_WB   = 2'b01,
        FWD_MEM  = 2'b10,
        FWD_AUX  = 2'b11
    } fwd_sel_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLT
    } alu_op_e;

    typedef struct packed {
        logic             valid;
        opcode_e          opcode;
        logic [2:0]       funct3;
        logic             funct7_5;
        logic [REG_W-1:0] rs1;
        logic [REG_W-1:0] rs2;
        logic [REG_W-1:0] rd;
        logic [XLEN-1:0]  imm;    // Sign-extended by the decoder.
    } issue_t;

    // A stage that writes the register file.
    typedef struct packed {
        logic             valid;
        logic [REG_W-1:0] rd;
        logic [XLEN-1:0]  data;
    } wb_bus_t;

    typedef struct packed {
        logic             valid;
        opcode_e          opcode;
        logic [REG_W-1:0] rd;
        logic             reg_write;
        logic [XLEN-1:0]  result;     // Store address for stores.
        logic [XLEN-1:0]  store_data;
        logic             taken;
    } retire_t;

endpackage

//--- verilog/forwarding_unit.sv
`timescale 1ns/1ps

module forwarding_unit (
    input  ex_pkg::opcode_e           ex_opcode,
    input  logic [ex_pkg::REG_W-1:0] rs1,
    input  logic [ex_pkg::REG_W-1:0] rs2,
    input  ex_pkg::wb_bus_t           mem_bus,
    input  ex_pkg::wb_bus_t           wb_bus,
    input  ex_pkg::wb_bus_t           aux_bus,
    input  logic                      fwd_en,
    input  logic                      aux_fwd_en,
    output ex_pkg::fwd_sel_e          fwd_a,
    output ex_pkg::fwd_sel_e          fwd_b
);

    logic use_a;
    logic use_b;

    // True when the bus writes a nonzero register matching rs.
    function automatic logic hits(input ex_pkg::wb_bus_t bus,
                                  input logic [ex_pkg::REG_W-1:0] rs);
        return bus.valid && (bus.rd != '0) && (bus.rd == rs);
    endfunction

    // Newest producer first.
    function automatic ex_pkg::fwd_sel_e search(input logic [ex_pkg::REG_W-1:0] rs);
        if (hits(mem_bus, rs)) begin
            return ex_pkg::FWD_MEM;
        end else if (hits(wb_bus, rs)) begin
            return ex_pkg::FWD_WB;
        end else if (aux_fwd_en && hits(aux_bus, rs)) begin
            return ex_pkg::FWD_AUX;
        end
        return ex_pkg::FWD_NONE;
    endfunction

    always_comb begin
        use_a = 1'b0;
        use_b = 1'b0;
        case (ex_opcode)
            ex_pkg::OP_REG, ex_pkg::OP_BRANCH: begin
                use_a = 1'b1;
                use_b = 1'b1;
            end
            ex_pkg::OP_STORE, ex_pkg::OP_IMM: begin
                use_a = 1'b1;  // Store data comes from the regfile.
            end
            default: ;
        endcase
    end

    always_comb begin
        fwd_a = (fwd_en && use_a) ? search(rs1) : ex_pkg::FWD_NONE;
        fwd_b = (fwd_en && use_b) ? search(rs2) : ex_pkg::FWD_NONE;
    end

endmodule

//--- verilog/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [ex_pkg::REG_W-1:0] rs1,
    input  logic [ex_pkg::REG_W-1:0] rs2,
    output logic [ex_pkg::XLEN-1:0]  rdata1,
    output logic [ex_pkg::XLEN-1:0]  rdata2,
    input  ex_pkg::wb_bus_t           wb_bus,
    input  ex_pkg::wb_bus_t           aux_bus
);

    logic [ex_pkg::XLEN-1:0] regs_q [1:31];  // x0 is not stored.

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else begin
            if (aux_bus.valid && (aux_bus.rd != '0)) begin
                regs_q[aux_bus.rd] <= aux_bus.data;
            end
            // Later assignment wins, so WB beats aux on a collision.
            if (wb_bus.valid && (wb_bus.rd != '0)) begin
                regs_q[wb_bus.rd] <= wb_bus.data;
            end
        end
    end

    assign rdata1 = (rs1 == '0) ? '0 : regs_q[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs_q[rs2];

endmodule

//--- verilog/ex_alu.sv
`timescale 1ns/1ps

module ex_alu (
    input  ex_pkg::issue_t           ex_issue,
    input  ex_pkg::alu_op_e          alu_op,
    input  logic [ex_pkg::XLEN-1:0] rdata1,
    input  logic [ex_pkg::XLEN-1:0] rdata2,
    input  logic [ex_pkg::XLEN-1:0] mem_data,
    input  logic [ex_pkg::XLEN-1:0] wb_data,
    input  logic [ex_pkg::XLEN-1:0] aux_data,
    input  ex_pkg::fwd_sel_e         fwd_a,
    input  ex_pkg::fwd_sel_e         fwd_b,
    output ex_pkg::retire_t          ex_result
);

    logic [ex_pkg::XLEN-1:0] op_a;
    logic [ex_pkg::XLEN-1:0] op_b;
    logic [ex_pkg::XLEN-1:0] alu_b;
    logic [ex_pkg::XLEN-1:0] alu_out;
    logic                    use_imm;
    logic                    is_store;
    logic                    operands_eq;

    function automatic logic [ex_pkg::XLEN-1:0] pick(input ex_pkg::fwd_sel_e sel,
                                                     input logic [ex_pkg::XLEN-1:0] rf_val);
        case (sel)
            ex_pkg::FWD_MEM: return mem_data;
            ex_pkg::FWD_WB:  return wb_data;
            ex_pkg::FWD_AUX: return aux_data;
            default:         return rf_val;
        endcase
    endfunction

    always_comb begin
        op_a = pick(fwd_a, rdata1);
        op_b = pick(fwd_b, rdata2);
    end

    assign is_store = (ex_issue.opcode == ex_pkg::OP_STORE);
    assign use_imm = (ex_issue.opcode == ex_pkg::OP_IMM) || is_store;
    assign alu_b = use_imm ? ex_issue.imm : op_b;
    assign operands_eq = (op_a == op_b);

    always_comb begin
        case (alu_op)
            ex_pkg::ALU_ADD: alu_out = op_a + alu_b;
            ex_pkg::ALU_SUB: alu_out = op_a - alu_b;
            ex_pkg::ALU_XOR: alu_out = op_a ^ alu_b;
            ex_pkg::ALU_OR:  alu_out = op_a | alu_b;
            ex_pkg::ALU_AND: alu_out = op_a & alu_b;
            ex_pkg::ALU_SLT: alu_out = {31'b0, $signed(op_a) < $signed(alu_b)};
            default:         alu_out = '0;
        endcase
    end

    always_comb begin
        ex_result = '0;
        ex_result.valid = ex_issue.valid;
        ex_result.opcode = ex_issue.opcode;
        ex_result.rd = ex_issue.rd;
        ex_result.reg_write = ((ex_issue.opcode == ex_pkg::OP_REG) ||
                               (ex_issue.opcode == ex_pkg::OP_IMM)) && (ex_issue.rd != '0);
        ex_result.result = alu_out;  // Address for stores.
        ex_result.store_data = is_store ? op_b : '0;
        if (ex_issue.opcode == ex_pkg::OP_BRANCH) begin
            case (ex_issue.funct3)
                3'b000:  ex_result.taken = operands_eq;   // BEQ.
                3'b001:  ex_result.taken = !operands_eq;  // BNE.
                default: ex_result.taken = 1'b0;
            endcase
        end
    end

endmodule

//--- verilog/hazard_ctrl_regs.sv
`timescale 1ns/1ps

module hazard_ctrl_regs #(
    parameter int COUNT_W = 16
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           cfg_req,
    input  logic                           cfg_we,
    input  logic [ex_pkg::CFG_ADDR_W-1:0] cfg_addr,
    input  logic [ex_pkg::XLEN-1:0]       cfg_wdata,
    output logic                           cfg_ack,
    output logic [ex_pkg::XLEN-1:0]       cfg_rdata,
    input  logic                           ex_valid,
    input  ex_pkg::fwd_sel_e              fwd_a,
    input  ex_pkg::fwd_sel_e              fwd_b,
    output logic                           fwd_en,
    output logic                           aux_fwd_en
);

    typedef enum logic [1:0] {
        IDLE,
        ACK,
        WAIT_DROP
    } cfg_state_e;

    cfg_state_e              state_q;
    cfg_state_e              state_d;
    logic [1:0]              ctrl_q;   // Bit 1 aux enable, bit 0 global enable.
    logic [COUNT_W-1:0]      count_q;
    logic [ex_pkg::XLEN-1:0] rdata_q;
    logic [ex_pkg::XLEN-1:0] rdata_d;
    logic                    access;
    logic                    count_clr;
    logic [1:0]              fwd_inc;
    logic [COUNT_W:0]        count_sum;

    assign access = (state_q == IDLE) && cfg_req;
    assign count_clr = access && cfg_we && (cfg_addr == ex_pkg::COUNT_ADDR);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:      if (cfg_req) state_d = ACK;
            ACK:       state_d = cfg_req ? WAIT_DROP : IDLE;
            WAIT_DROP: if (!cfg_req) state_d = IDLE;
            default:   state_d = IDLE;
        endcase
    end

    always_comb begin
        rdata_d = '0;
        if (cfg_addr == ex_pkg::CTRL_ADDR) begin
            rdata_d[1:0] = ctrl_q;
        end else begin
            rdata_d[COUNT_W-1:0] = count_q;  // Zero-extended.
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= IDLE;
            ctrl_q <= 2'b11;
        end else begin
            state_q <= state_d;
            if (access && cfg_we && (cfg_addr == ex_pkg::CTRL_ADDR)) begin
                ctrl_q <= cfg_wdata[1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            rdata_q <= rdata_d;  // Held while ack is high.
        end
    end

    assign fwd_inc = {1'b0, fwd_a != ex_pkg::FWD_NONE} + {1'b0, fwd_b != ex_pkg::FWD_NONE};
    assign count_sum = {1'b0, count_q} + {{(COUNT_W-1){1'b0}}, fwd_inc};

    always_ff @(posedge clk) begin
        if (!rst_n || count_clr) begin
            count_q <= '0;  // Clear beats increment.
        end else if (ex_valid) begin
            count_q <= count_sum[COUNT_W] ? '1 : count_sum[COUNT_W-1:0];
        end
    end

    assign cfg_ack = (state_q != IDLE);
    assign cfg_rdata = rdata_q;
    assign fwd_en = ctrl_q[0];
    assign aux_fwd_en = ctrl_q[1];

endmodule

//--- verilog/ex_pipeline_top.sv
`timescale 1ns/1ps

module ex_pipeline_top #(
    parameter int COUNT_W = 16
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  ex_pkg::issue_t                 issue,
    input  ex_pkg::wb_bus_t                aux_wb,
    output ex_pkg::retire_t                retire,
    input  logic                           cfg_req,
    input  logic                           cfg_we,
    input  logic [ex_pkg::CFG_ADDR_W-1:0] cfg_addr,
    input  logic [ex_pkg::XLEN-1:0]       cfg_wdata,
    output logic                           cfg_ack,
    output logic [ex_pkg::XLEN-1:0]       cfg_rdata
);

    ex_pkg::issue_t          idex_q;
    ex_pkg::alu_op_e         idex_alu_op_q;
    ex_pkg::retire_t         ex_result;
    ex_pkg::retire_t         exmem_q;
    ex_pkg::retire_t         memwb_q;
    ex_pkg::wb_bus_t         mem_bus;
    ex_pkg::wb_bus_t         wb_bus;
    logic [ex_pkg::XLEN-1:0] rdata1;
    logic [ex_pkg::XLEN-1:0] rdata2;
    ex_pkg::fwd_sel_e        fwd_a;
    ex_pkg::fwd_sel_e        fwd_b;
    logic                    fwd_en;
    logic                    aux_fwd_en;

    // funct3 and funct7[5] to ALU op; stores and branches add.
    function automatic ex_pkg::alu_op_e decode_alu_op(input ex_pkg::issue_t ins);
        ex_pkg::alu_op_e op;
        op = ex_pkg::ALU_ADD;
        if ((ins.opcode == ex_pkg::OP_REG) || (ins.opcode == ex_pkg::OP_IMM)) begin
            case (ins.funct3)
                3'b000: begin
                    if ((ins.opcode == ex_pkg::OP_REG) && ins.funct7_5) begin
                        op = ex_pkg::ALU_SUB;
                    end
                end
                3'b010:  op = ex_pkg::ALU_SLT;
                3'b100:  op = ex_pkg::ALU_XOR;
                3'b110:  op = ex_pkg::ALU_OR;
                3'b111:  op = ex_pkg::ALU_AND;
                default: op = ex_pkg::ALU_ADD;
            endcase
        end
        return op;
    endfunction

    // ID/EX, EX/MEM and MEM/WB advance every edge.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            idex_q.valid <= 1'b0;
            exmem_q.valid <= 1'b0;
            memwb_q.valid <= 1'b0;
        end else begin
            idex_q <= issue;
            exmem_q <= ex_result;
            memwb_q <= exmem_q;
        end
    end

    always_ff @(posedge clk) begin
        idex_alu_op_q <= decode_alu_op(issue);
    end

    always_comb begin
        mem_bus.valid = exmem_q.valid && exmem_q.reg_write;
        mem_bus.rd = exmem_q.rd;
        mem_bus.data = exmem_q.result;
        wb_bus.valid = memwb_q.valid && memwb_q.reg_write;
        wb_bus.rd = memwb_q.rd;
        wb_bus.data = memwb_q.result;
    end

    assign retire = memwb_q;

    forwarding_unit forwarding_unit_i (
        .ex_opcode  (idex_q.opcode),
        .rs1        (idex_q.rs1),
        .rs2        (idex_q.rs2),
        .mem_bus    (mem_bus),
        .wb_bus     (wb_bus),
        .aux_bus    (aux_wb),
        .fwd_en     (fwd_en),
        .aux_fwd_en (aux_fwd_en),
        .fwd_a      (fwd_a),
        .fwd_b      (fwd_b)
    );

    regfile regfile_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs1     (idex_q.rs1),
        .rs2     (idex_q.rs2),
        .rdata1  (rdata1),
        .rdata2  (rdata2),
        .wb_bus  (wb_bus),
        .aux_bus (aux_wb)
    );

    ex_alu ex_alu_i (
        .ex_issue  (idex_q),
        .alu_op    (idex_alu_op_q),
        .rdata1    (rdata1),
        .rdata2    (rdata2),
        .mem_data  (mem_bus.data),
        .wb_data   (wb_bus.data),
        .aux_data  (aux_wb.data),
        .fwd_a     (fwd_a),
        .fwd_b     (fwd_b),
        .ex_result (ex_result)
    );

    hazard_ctrl_regs #(
        .COUNT_W (COUNT_W)
    ) hazard_ctrl_regs_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg_req    (cfg_req),
        .cfg_we     (cfg_we),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .cfg_ack    (cfg_ack),
        .cfg_rdata  (cfg_rdata),
        .ex_valid   (idex_q.valid),
        .fwd_a      (fwd_a),
        .fwd_b      (fwd_b),
        .fwd_en     (fwd_en),
        .aux_fwd_en (aux_fwd_en)
    );

endmodule

//--- verif/ex_pipeline_assertions.sv
`timescale 1ns/1ps

module ex_pipeline_assertions (
    input logic             clk,
    input logic             rst_n,
    input logic             cfg_req,
    input logic             cfg_ack,
    input ex_pkg::issue_t   issue,
    input ex_pkg::retire_t  retire,
    input ex_pkg::fwd_sel_e fwd_a,
    input ex_pkg::fwd_sel_e fwd_b,
    input logic             fwd_en
);

    // Ack only answers a pending request.
    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(cfg_ack) |-> cfg_req)
        else $error("cfg_ack rose without cfg_req");

    ack_drops: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(cfg_req) |=> !cfg_ack)
        else $error("cfg_ack still high one cycle after cfg_req fell");

    // Three edges from issue to retire.
    retire_has_issue: assert property (@(posedge clk) disable iff (!rst_n)
        retire.valid |-> $past(issue.valid, 3))
        else $error("retire.valid without an issue three cycles earlier");

    no_fwd_when_off: assert property (@(posedge clk) disable iff (!rst_n)
        !fwd_en |-> (fwd_a == ex_pkg::FWD_NONE) && (fwd_b == ex_pkg::FWD_NONE))
        else $error("operand forwarded while forwarding is disabled");

endmodule

//--- verif/tb_ex_pipeline.sv
`timescale 1ns/1ps

module tb_ex_pipeline;

    logic                           clk;
    logic                           rst_n;
    ex_pkg::issue_t                 issue;
    ex_pkg::wb_bus_t                aux_wb;
    ex_pkg::retire_t                retire;
    logic                           cfg_req;
    logic                           cfg_we;
    logic [ex_pkg::CFG_ADDR_W-1:0] cfg_addr;
    logic [ex_pkg::XLEN-1:0]       cfg_wdata;
    logic                           cfg_ack;
    logic [ex_pkg::XLEN-1:0]       cfg_rdata;

    byte             rec_kind[$];
    ex_pkg::issue_t  rec_issue[$];
    ex_pkg::wb_bus_t rec_aux[$];
    ex_pkg::retire_t rec_exp[$];
    logic [31:0]     rec_addr[$];
    logic [31:0]     rec_data[$];
    string           rec_name[$];
    ex_pkg::retire_t exp_q[$];  // One entry per driven cycle.
    int              checks = 0;
    int              errors = 0;
    int              test_errors = 0;
    string           test_name = "";
    int              limit_cycles = 0;

    ex_pipeline_top #(.COUNT_W(16)) ex_pipeline_top_i (.*);

    bind ex_pipeline_top ex_pipeline_assertions ex_pipeline_assertions_i (
        .clk(clk), .rst_n(rst_n), .cfg_req(cfg_req), .cfg_ack(cfg_ack), .issue(issue),
        .retire(retire), .fwd_a(fwd_a), .fwd_b(fwd_b), .fwd_en(fwd_en)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic load_vectors(output bit ok);
        int          fd;
        int          n;
        string       kind;
        string       text;
        logic [31:0] v [0:17];
        ok = 1'b0;
        fd = $fopen("verif/ex_vectors.txt", "r");
        if (fd == 0) return;
        while (!$feof(fd)) begin
            n = $fscanf(fd, "%s", kind);
            if (n != 1) break;
            if (kind == "#") begin
                n = $fgets(text, fd);  // Column notes.
                continue;
            end
            foreach (v[i]) v[i] = '0;
            text = "";
            if (kind == "T") n = $fscanf(fd, "%s", text);
            else if (kind == "D") n = $fscanf(fd, "%d", v[1]);
            else if (kind == "W" || kind == "R") n = $fscanf(fd, "%h %h", v[0], v[1]);
            else if (kind == "I") foreach (v[j]) n = $fscanf(fd, "%h", v[j]);
            else break;
            rec_kind.push_back(kind.getc(0));
            rec_name.push_back(text);
            rec_addr.push_back(v[0]);
            rec_data.push_back(v[1]);
            rec_issue.push_back({v[0][0], ex_pkg::opcode_e'(v[1][6:0]), v[2][2:0], v[3][0],
                                 v[4][4:0], v[5][4:0], v[6][4:0], v[7]});
            rec_aux.push_back({v[8][0], v[9][4:0], v[10]});
            rec_exp.push_back({v[11][0], ex_pkg::opcode_e'(v[12][6:0]), v[13][4:0], v[14][0],
                               v[15], v[16], v[17][0]});
        end
        $fclose(fd);
        ok = (rec_kind.size() > 0);
    endtask

    // Drives one cycle and records what must retire three edges later.
    task automatic step(input ex_pkg::issue_t ins, input ex_pkg::wb_bus_t aux,
                        input ex_pkg::retire_t exp);
        @(posedge clk);
        issue <= ins;
        aux_wb <= aux;
        exp_q.push_back(exp);
    endtask

    task automatic idle_step();
        step('0, '0, '0);
    endtask

    task automatic compare_retire(input ex_pkg::retire_t got, input ex_pkg::retire_t exp);
        checks++;
        if (exp.valid ? (got !== exp) : (got.valid !== 1'b0)) begin
            $display("FAILED at %0t: retire got %h, expected %h", $time, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic compare_cfg(input logic [ex_pkg::XLEN-1:0] got,
                               input logic [ex_pkg::XLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            $display("FAILED at %0t: cfg_rdata got %h, expected %h", $time, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    // Retire of the oldest driven cycle is stable at the falling edge.
    always @(negedge clk) begin
        if (rst_n && exp_q.size() == 4) begin
            compare_retire(retire, exp_q.pop_front());
        end
    end

    task automatic cfg_access(input logic we, input logic [ex_pkg::CFG_ADDR_W-1:0] addr,
                              input logic [ex_pkg::XLEN-1:0] data,
                              input logic [ex_pkg::XLEN-1:0] exp);
        int gap;
        int waited;
        gap = $urandom_range(2, 0);
        repeat (gap) idle_step();
        idle_step();
        cfg_req <= 1'b1;
        cfg_we <= we;
        cfg_addr <= addr;
        cfg_wdata <= data;
        waited = 0;
        @(negedge clk);
        while (!cfg_ack && waited < 8) begin
            idle_step();
            @(negedge clk);
            waited++;
        end
        if (!cfg_ack) begin
            $display("Control port never acknowledged the access at %0t", $time);
            errors++;
            test_errors++;
        end else if (!we) begin
            compare_cfg(cfg_rdata, exp);
        end
        idle_step();
        cfg_req <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (cfg_ack && waited < 8) begin
            idle_step();
            @(negedge clk);
            waited++;
        end
        if (cfg_ack) begin
            $display("Control port kept ack high after the request dropped at %0t", $time);
            errors++;
            test_errors++;
        end
    endtask

    task automatic close_test();
        if (test_name != "") begin
            $display("test %s: %0d errors, %s", test_name, test_errors,
                     (test_errors == 0) ? "pass" : "fail");
        end
        test_errors = 0;
    endtask

    // Watchdog sized from the number of records.
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles", limit_cycles);
        $display("Test failed");
        $finish;
    end

    initial begin
        int unsigned seed_val;
        bit          ok;
        rst_n = 1'b0;
        issue = '0;
        aux_wb = '0;
        cfg_req = 1'b0;
        cfg_we = 1'b0;
        cfg_addr = '0;
        cfg_wdata = '0;
        seed_val = $urandom(32'h747e_18f0);
        load_vectors(ok);
        if (!ok) begin
            $display("Could not read any records from verif/ex_vectors.txt");
            $display("Test failed");
            $finish;
        end else begin
            limit_cycles = rec_kind.size() * 12 + 20;
            repeat (3) @(posedge clk);
            rst_n <= 1'b1;
            foreach (rec_kind[i]) begin
                case (rec_kind[i])
                    "T": begin
                        close_test();
                        test_name = rec_name[i];
                    end
                    "I": step(rec_issue[i], rec_aux[i], rec_exp[i]);
                    "D": repeat (rec_data[i]) idle_step();
                    "W": cfg_access(1'b1, rec_addr[i][0], rec_data[i], '0);
                    default: cfg_access(1'b0, rec_addr[i][0], '0, rec_data[i]);
                endcase
            end
            repeat (4) idle_step();
            @(posedge clk);
            close_test();
            $display("Summary: %0d checks, %0d errors", checks, errors);
            if (errors == 0) begin
                $display("Test completed successfully");
            end else begin
                $display("Test failed");
            end
            $finish;
        end
    end

endmodule

//--- all.f
verilog/ex_pkg.sv
verilog/forwarding_unit.sv
verilog/regfile.sv
verilog/ex_alu.sv
verilog/hazard_ctrl_regs.sv
verilog/ex_pipeline_top.sv
verif/ex_pipeline_assertions.sv
verif/tb_ex_pipeline.sv

//--- run_sim.sh
#!/bin/sh
# Builds with Verilator, runs the testbench and scans sim.log for the result.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_ex_pipeline \
    -o tb_ex_pipeline_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_ex_pipeline_sim > sim.log 2>&1
cat sim.log
grep -q "Test failed" sim.log && exit 1
grep -q "Test completed successfully" sim.log || exit 1
exit 0

//--- verif/ex_vectors.txt
# I: v op f3 f7_5 rs1 rs2 rd imm | aux v rd data | exp v op rd wr result sdata taken (hex)
# T name, D idle cycles, W addr data, R addr expected; aux meets the previous record in EX
T alu_chain
I 1 13 0 0 0 0 1 5 0 0 0 1 13 1 1 5 0 0
I 1 33 0 0 1 1 2 0 0 0 0 1 33 2 1 a 0 0
I 1 33 0 1 2 1 3 0 0 0 0 1 33 3 1 5 0 0
I 1 33 4 0 3 2 4 0 0 0 0 1 33 4 1 f 0 0
I 1 33 6 0 4 1 5 0 0 0 0 1 33 5 1 f 0 0
I 1 33 7 0 5 4 6 0 0 0 0 1 33 6 1 f 0 0
I 1 33 2 0 1 6 7 0 0 0 0 1 33 7 1 1 0 0
D 4
R 1 a
W 1 0
T distance
I 1 13 0 0 0 0 8 20 0 0 0 1 13 8 1 20 0 0
I 1 13 0 0 0 0 9 3 0 0 0 1 13 9 1 3 0 0
I 1 33 0 0 8 9 a 0 0 0 0 1 33 a 1 23 0 0
I 1 33 0 0 8 0 b 0 0 0 0 1 33 b 1 20 0 0
I 1 13 0 0 0 0 c 1 0 0 0 1 13 c 1 1 0 0
I 1 13 0 0 0 0 c 2 0 0 0 1 13 c 1 2 0 0
I 1 33 0 0 c 0 d 0 0 0 0 1 33 d 1 2 0 0
T aux
I 1 33 0 0 14 0 e 0 0 0 0 1 33 e 1 77 0 0
I 0 0 0 0 0 0 0 0 1 14 77 0 0 0 0 0 0 0
I 1 13 0 0 0 0 f 9 0 0 0 1 13 f 1 9 0 0
I 1 33 0 0 f 0 10 0 0 0 0 1 33 10 1 9 0 0
I 0 0 0 0 0 0 0 0 1 f 55 0 0 0 0 0 0 0
D 4
W 0 1
R 0 1
I 1 33 0 0 15 0 11 0 0 0 0 1 33 11 1 0 0 0
I 0 0 0 0 0 0 0 0 1 15 99 0 0 0 0 0 0 0
D 4
W 0 3
T fwd_off
W 0 0
R 0 0
I 1 13 0 0 0 0 12 40 0 0 0 1 13 12 1 40 0 0
I 1 33 0 0 12 12 13 0 0 0 0 1 33 13 1 0 0 0
I 1 13 0 0 12 0 16 1 0 0 0 1 13 16 1 1 0 0
D 4
W 0 3
I 1 33 0 0 13 12 17 0 0 0 0 1 33 17 1 40 0 0
I 1 33 0 0 17 12 18 0 0 0 0 1 33 18 1 80 0 0
T operand_class
I 1 13 0 0 0 0 0 5a 0 0 0 1 13 0 0 5a 0 0
I 1 33 0 0 0 0 19 0 0 0 0 1 33 19 1 0 0 0
I 1 13 0 0 0 0 1a 11 0 0 0 1 13 1a 1 11 0 0
I 1 13 0 0 0 0 1b 100 0 0 0 1 13 1b 1 100 0 0
I 1 23 0 0 1b 1a 0 4 0 0 0 1 23 0 0 104 0 0
I 1 63 0 0 1a 1b 0 0 0 0 0 1 63 0 0 111 0 0
I 1 13 0 0 0 0 1c 11 0 0 0 1 13 1c 1 11 0 0
I 1 63 0 0 1c 1a 0 0 0 0 0 1 63 0 0 22 0 1
I 1 63 1 0 1c 1b 0 0 0 0 0 1 63 0 0 111 0 1
T control
D 4
R 1 a
W 1 0
R 1 0
R 0 3
